/* common/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Core sizing

// Bus, register and ALU width
`define DATA_W 8

// General registers
`define NUM_REGS 4

// First fetch address after reset
`define RESET_PC 0

// Clock cycles per byte on the multiplexed bus
`define FETCH_PHASES 5

`endif

/* common/opcodes.sv */
`include "cpu_defines.svh"

package opcodes;

   typedef logic [`DATA_W-1:0]            dataT;
   typedef logic [`DATA_W-1:0]            addrT;
   typedef logic [$clog2(`NUM_REGS)-1:0]  regIdxT;

   // Upper nibble of the instruction byte
   typedef enum logic [3:0] {
      NOP  = 4'd0,
      ADD  = 4'd1,
      ADC  = 4'd2,
      SUB  = 4'd3,
      AND  = 4'd4,
      OR   = 4'd5,
      XOR  = 4'd6,
      ADDI = 4'd7,
      ADCI = 4'd8,
      LDI  = 4'd9,
      LD   = 4'd10,
      ST   = 4'd11,
      JMP  = 4'd12,
      JZ   = 4'd13,
      CALL = 4'd14,
      RET  = 4'd15   // HALT when bit 0 of the byte is set
   } opCodeT;

   typedef enum logic [2:0] {
      FnNOP,
      FnADD,
      FnADC,
      FnSUB,
      FnAND,
      FnOR,
      FnXOR,
      FnPASS         // Operand 2 straight through
   } aluFunctionsT;

   typedef enum logic [1:0] {
      PcInc,
      PcOperand,
      PcLink
   } pcSelectT;

   typedef enum logic [2:0] {
      fetch,
      operand,
      execute,
      memory,
      halted
   } stateT;

   // Sub-states of every bus transfer
   typedef enum logic [$clog2(`FETCH_PHASES)-1:0] {
      latch1,
      latch2,
      latch3,
      latch4,
      irGet
   } phaseT;

endpackage

/* hw/alu.sv */
`include "cpu_defines.svh"

module alu import opcodes::*; (
   input  aluFunctionsT Fn,
   input  dataT         A,
   input  dataT         B,
   input  logic         CarryIn,
   output dataT         Result,
   output logic         CarryOut,
   output logic         Zero
);

   logic [`DATA_W:0] sum;

   always_comb begin
      sum      = '0;
      Result   = A;
      CarryOut = 1'b0;
      case (Fn)
         FnADD: begin
            sum      = {1'b0, A} + {1'b0, B};
            Result   = sum[`DATA_W-1:0];
            CarryOut = sum[`DATA_W];
         end
         FnADC: begin
            sum      = {1'b0, A} + {1'b0, B} + {{`DATA_W{1'b0}}, CarryIn};
            Result   = sum[`DATA_W-1:0];
            CarryOut = sum[`DATA_W];
         end
         FnSUB: begin
            // Two's complement, carry set means no borrow
            sum      = {1'b0, A} + {1'b0, ~B} + {{`DATA_W{1'b0}}, 1'b1};
            Result   = sum[`DATA_W-1:0];
            CarryOut = sum[`DATA_W];
         end
         FnAND:   Result = A & B;
         FnOR:    Result = A | B;
         FnXOR:   Result = A ^ B;
         FnPASS:  Result = B;
         default: Result = A;
      endcase
   end

   assign Zero = (Result == '0);

endmodule

/* hw/regFile.sv */
`include "cpu_defines.svh"

module regFile import opcodes::*; (
   input  logic   Clock,
   input  logic   nReset,
   input  regIdxT RdAddrA,
   input  regIdxT RdAddrB,
   input  regIdxT WrAddr,
   input  dataT   WrData,
   input  logic   We,
   output dataT   RdDataA,
   output dataT   RdDataB
);

   dataT regs [`NUM_REGS];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < `NUM_REGS; i++)
            regs[i] <= '0;
      end else if (We) begin
         regs[WrAddr] <= WrData;
      end
   end

   // Asynchronous read ports
   assign RdDataA = regs[RdAddrA];
   assign RdDataB = regs[RdAddrB];

endmodule

/* hw/control/control.sv */
module control import opcodes::*; (
   input  logic         Clock,
   input  logic         nReset,
   input  opCodeT       OpCode,
   input  logic         HaltBit,
   input  logic         Z,
   output aluFunctionsT AluOp,
   output logic         Op1Sel,     // 1 selects rd, 0 the PC
   output logic [1:0]   Op2Sel,     // 0 rs, 1 operand byte, 2 zero
   output logic         WdSel,      // 1 takes bus data
   output logic         ImmSel,
   output logic         RegWe,
   output logic         IrWe,
   output logic         PcEn,
   output logic         PcWe,
   output pcSelectT     PcSel,
   output logic         LrWe,
   output logic         AluEn,
   output logic         Rw,
   output logic         MemEn,      // Core drives the AD pads
   output logic         ALE,
   output logic         nOE,
   output logic         nWE,
   output logic         nME,
   output logic         ENB,
   output logic         Halted
);

   stateT state;
   stateT nextState;
   phaseT phase;
   logic  busState;
   logic  needsOperand;
   logic  isStore;

   assign busState     = (state == fetch) || (state == operand) || (state == memory);
   assign needsOperand = OpCode inside {ADDI, ADCI, LDI, JMP, JZ, CALL};
   assign isStore      = (state == memory) && (OpCode == ST);
   assign Halted       = (state == halted);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state <= fetch;
         phase <= latch1;
      end else begin
         state <= nextState;
         if (!busState || phase == irGet)
            phase <= latch1;
         else
            phase <= phaseT'(phase + 1'b1);
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         fetch: begin
            // OpCode is bypassed from the pads during irGet
            if (phase == irGet)
               nextState = needsOperand ? operand : execute;
         end
         operand: begin
            if (phase == irGet)
               nextState = execute;
         end
         execute: begin
            if (OpCode == LD || OpCode == ST)
               nextState = memory;
            else if (OpCode == RET && HaltBit)
               nextState = halted;
            else
               nextState = fetch;
         end
         memory: begin
            if (phase == irGet)
               nextState = fetch;
         end
         halted:  nextState = halted;
         default: nextState = fetch;
      endcase
   end

   // Pad strobes
   always_comb begin
      MemEn = 1'b0;
      ALE   = 1'b0;
      nOE   = 1'b1;
      nWE   = 1'b1;
      nME   = 1'b1;
      ENB   = 1'b0;
      if (busState) begin
         case (phase)
            latch1: begin
               MemEn = 1'b1;
               nME   = 1'b0;
            end
            latch2: begin
               MemEn = 1'b1;
               ALE   = 1'b1;
               nME   = 1'b0;
            end
            latch3, latch4: begin
               nME = 1'b0;
               if (isStore) begin
                  MemEn = 1'b1;   // Store data on AD
                  nWE   = 1'b0;
               end else begin
                  nOE = 1'b0;
               end
            end
            irGet: begin
               ENB = 1'b1;
               // Read data kept valid through the capture edge
               if (!isStore)
                  nOE = 1'b0;
            end
            default: ;
         endcase
      end
   end

   // Datapath controls
   always_comb begin
      AluOp  = FnNOP;
      Op1Sel = 1'b0;
      Op2Sel = 2'd0;
      WdSel  = 1'b0;
      ImmSel = 1'b0;
      RegWe  = 1'b0;
      IrWe   = 1'b0;
      PcEn   = 1'b0;
      PcWe   = 1'b0;
      PcSel  = PcInc;
      LrWe   = 1'b0;
      AluEn  = 1'b0;
      Rw     = 1'b0;
      case (state)
         fetch: begin
            IrWe = (phase == irGet);
            PcEn = (phase == irGet);
         end
         operand: begin
            ImmSel = (phase == irGet);
            PcEn   = (phase == irGet);
         end
         execute: begin
            case (OpCode)
               ADD, ADC, SUB, AND, OR, XOR, ADDI, ADCI: begin
                  Op1Sel = 1'b1;
                  RegWe  = 1'b1;
                  AluEn  = 1'b1;
                  if (OpCode == ADDI || OpCode == ADCI)
                     Op2Sel = 2'd1;
                  case (OpCode)
                     ADD, ADDI: AluOp = FnADD;
                     ADC, ADCI: AluOp = FnADC;
                     SUB:       AluOp = FnSUB;
                     AND:       AluOp = FnAND;
                     OR:        AluOp = FnOR;
                     default:   AluOp = FnXOR;
                  endcase
               end
               LDI: begin
                  AluOp  = FnPASS;
                  Op2Sel = 2'd1;
                  RegWe  = 1'b1;
               end
               LD, ST: Rw = 1'b1;   // rs onto the pads ahead of latch1
               JMP, JZ, CALL: begin
                  PcSel = PcOperand;
                  PcWe  = (OpCode != JZ) || Z;
                  LrWe  = (OpCode == CALL);
               end
               RET: begin
                  PcSel = PcLink;
                  PcWe  = !HaltBit;
               end
               default: ;
            endcase
         end
         memory: begin
            Rw = 1'b1;
            if (isStore && (phase == latch3 || phase == latch4))
               Op1Sel = 1'b1;   // rd data instead of the address
            if (!isStore && phase == irGet) begin
               WdSel = 1'b1;
               RegWe = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

/* hw/datapath/datapath.sv */
`include "cpu_defines.svh"

module datapath import opcodes::*; (
   input  logic         Clock,
   input  logic         nReset,
   input  aluFunctionsT AluOp,
   input  logic         Op1Sel,
   input  logic [1:0]   Op2Sel,
   input  logic         WdSel,
   input  logic         ImmSel,
   input  logic         RegWe,
   input  logic         IrWe,
   input  logic         PcEn,
   input  logic         PcWe,
   input  pcSelectT     PcSel,
   input  logic         LrWe,
   input  logic         AluEn,
   input  logic         Rw,
   input  dataT         AdIn,
   output addrT         AdOut,
   output opCodeT       OpCode,
   output logic         HaltBit,
   output logic         Z,
   output regIdxT       RdAddrA,
   output regIdxT       RdAddrB,
   output regIdxT       WrAddr,
   output dataT         WrData,
   input  dataT         RdDataA,
   input  dataT         RdDataB,
   output dataT         AluA,
   output dataT         AluB,
   output logic         CarryIn,
   input  dataT         AluResult,
   input  logic         AluCarry,
   input  logic         AluZero
);

   addrT pc;
   addrT lr;
   dataT ir;
   dataT operandByte;
   dataT irNext;
   logic carryFlag;
   logic zeroFlag;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= addrT'(`RESET_PC);
      end else if (PcWe) begin
         case (PcSel)
            PcOperand: pc <= operandByte;
            PcLink:    pc <= lr;
            default:   pc <= pc + 1'b1;
         endcase
      end else if (PcEn) begin
         pc <= pc + 1'b1;
      end
   end

   // IR cleared to NOP
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         ir <= '0;
      else if (IrWe)
         ir <= AdIn;
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         carryFlag <= 1'b0;
         zeroFlag  <= 1'b0;
      end else if (AluEn) begin
         carryFlag <= AluCarry;
         zeroFlag  <= AluZero;
      end
   end

   always_ff @(posedge Clock) begin
      if (ImmSel)
         operandByte <= AdIn;
      if (LrWe)
         lr <= pc;   // Already past the operand byte
   end

   // Control sees the new opcode while it is still on the pads
   assign irNext  = IrWe ? AdIn : ir;
   assign OpCode  = opCodeT'(irNext[7:4]);
   assign HaltBit = irNext[0];
   assign Z       = zeroFlag;

   assign RdAddrA = ir[3:2];   // rd
   assign RdAddrB = ir[1:0];   // rs
   assign WrAddr  = ir[3:2];

   assign AluA    = Op1Sel ? RdDataA : pc;
   assign CarryIn = carryFlag;

   always_comb begin
      case (Op2Sel)
         2'd0:    AluB = RdDataB;
         2'd1:    AluB = operandByte;
         default: AluB = '0;
      endcase
   end

   assign WrData = WdSel ? AdIn : AluResult;

   // Address from PC or rs, store data from rd
   always_comb begin
      if (!Rw)
         AdOut = pc;
      else if (Op1Sel)
         AdOut = RdDataA;
      else
         AdOut = RdDataB;
   end

endmodule

/* hw/cpuTop.sv */
module cpuTop import opcodes::*; (
   input  logic Clock,
   input  logic nReset,
   input  dataT AdIn,
   output dataT AdOut,
   output logic ALE,
   output logic nOE,
   output logic nWE,
   output logic nME,
   output logic ENB,
   output logic MemEn,
   output logic Halted
);

   aluFunctionsT AluOp;
   pcSelectT     PcSel;
   opCodeT       OpCode;
   logic [1:0]   Op2Sel;
   logic         Op1Sel;
   logic         WdSel;
   logic         ImmSel;
   logic         RegWe;
   logic         IrWe;
   logic         PcEn;
   logic         PcWe;
   logic         LrWe;
   logic         AluEn;
   logic         Rw;
   logic         HaltBit;
   logic         Z;
   regIdxT       RdAddrA;
   regIdxT       RdAddrB;
   regIdxT       WrAddr;
   dataT         WrData;
   dataT         RdDataA;
   dataT         RdDataB;
   dataT         AluA;
   dataT         AluB;
   dataT         AluResult;
   logic         CarryIn;
   logic         AluCarry;
   logic         AluZero;

   control u_control (.*);

   datapath u_datapath (.*);

   regFile u_regFile (
      .*,
      .We (RegWe)
   );

   alu u_alu (
      .Fn       (AluOp),
      .A        (AluA),
      .B        (AluB),
      .CarryIn  (CarryIn),
      .Result   (AluResult),
      .CarryOut (AluCarry),
      .Zero     (AluZero)
   );

endmodule

/* dv/memModel.sv */
`include "cpu_defines.svh"

module memModel import opcodes::*; (
   input  logic Clock,
   input  logic nReset,
   input  logic ALE,
   input  logic nOE,
   input  logic nWE,
   input  logic nME,
   input  dataT AdOut,
   output dataT AdIn,
   input  logic LoadEn,      // Image load, only while the core is idle
   input  addrT LoadAddr,
   input  dataT LoadData,
   output addrT LastAddr,
   output dataT LastData,
   output int   WriteCount
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MemBytes = 1 << `DATA_W;

   dataT mem [MemBytes];
   addrT addrLatch;
   logic weSeen;             // Strobe already taken this transfer
   logic writeStart;

   assign writeStart = !nME && !nWE && !weSeen;
   assign AdIn       = nOE ? '0 : mem[addrLatch];

   always @(posedge Clock) begin
      if (!nME && ALE)
         addrLatch <= AdOut;
      if (LoadEn)
         mem[LoadAddr] <= LoadData;
      else if (writeStart)
         mem[addrLatch] <= AdOut;
   end

   // Write log, cleared together with the core
   always @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         weSeen     <= 1'b0;
         LastAddr   <= '0;
         LastData   <= '0;
         WriteCount <= 0;
      end else begin
         weSeen <= !nWE;
         if (writeStart) begin
            LastAddr   <= addrLatch;
            LastData   <= AdOut;
            WriteCount <= WriteCount + 1;
         end
      end
   end

endmodule

/* dv/tbCpu.sv */
`include "cpu_defines.svh"

module tbCpu import opcodes::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NumProgs        = 5;
   localparam int CodeBytes       = 16;
   localparam int MemBytes        = 1 << `DATA_W;
   localparam int ResetCycles     = 8;
   localparam int AfterHaltCycles = 12;
   localparam int RegOpCycles     = `FETCH_PHASES + 1;
   localparam int LongOpCycles    = 2 * `FETCH_PHASES + 1;
   localparam int OverheadCycles  = MemBytes + 1 + ResetCycles + AfterHaltCycles + 2;
   localparam int MarginCycles    = 100;
   localparam dataT HaltByte      = {RET, 4'b0001};

   logic Clock;
   logic nReset;
   dataT AdIn;
   dataT AdOut;
   logic ALE, nOE, nWE, nME, ENB, MemEn, Halted;
   logic LoadEn;
   addrT LoadAddr;
   dataT LoadData;
   addrT LastAddr;
   dataT LastData;
   int   WriteCount;

   // Program table
   dataT  code [NumProgs][CodeBytes];
   string progName [NumProgs];
   addrT  preAddr [NumProgs];      // One preloaded data byte
   dataT  preData [NumProgs];
   addrT  storeAddr [NumProgs];
   dataT  storeData [NumProgs];
   int    shortOps [NumProgs];     // Executed 6 cycle instructions
   int    longOps [NumProgs];      // Executed 11 cycle instructions
   int    budgetCycles;

   cpuTop dut (.*);

   memModel memory (.*);

   always #2 Clock = ~Clock;

   function automatic dataT instr(opCodeT op, int rd, int rs);
      return {op, regIdxT'(rd), regIdxT'(rs)};
   endfunction

   function automatic int predictCycles(int p);
      return shortOps[p] * RegOpCycles + longOps[p] * LongOpCycles;
   endfunction

   // One bus transfer per short op, two per long op
   function automatic int predictTransfers(int p);
      return shortOps[p] + 2 * longOps[p];
   endfunction

   function automatic dataT imageByte(int p, int a);
      if (a < CodeBytes)
         return code[p][a];
      if (addrT'(a) == preAddr[p])
         return preData[p];
      return dataT'(a) ^ 8'hA5;   // Fill
   endfunction

   task automatic setProg(int p, string name, addrT preA, dataT preD, addrT stA, dataT stD,
                          int nShort, int nLong);
      progName[p]  = name;
      preAddr[p]   = preA;
      preData[p]   = preD;
      storeAddr[p] = stA;
      storeData[p] = stD;
      shortOps[p]  = nShort;
      longOps[p]   = nLong;
   endtask

   task automatic buildTable();
      code[0] = '{instr(LDI, 0, 0), 8'hC5, instr(LDI, 1, 0), 8'h6E, instr(LDI, 2, 0), 8'h80,
                  instr(ADD, 0, 1), instr(ST, 0, 2), HaltByte, HaltByte, HaltByte, HaltByte,
                  HaltByte, HaltByte, HaltByte, HaltByte};
      setProg(0, "add and store", 8'hC0, 8'h00, 8'h80, dataT'(8'hC5 + 8'h6E), 2, 4);
      code[1] = '{instr(LDI, 0, 0), 8'hF0, instr(LDI, 1, 0), 8'h20, instr(ADD, 0, 1),
                  instr(ADCI, 0, 0), 8'h05, instr(ADC, 0, 1), instr(SUB, 0, 1),
                  instr(LDI, 2, 0), 8'h4B, instr(AND, 0, 2), instr(OR, 0, 1),
                  instr(XOR, 0, 2), instr(ST, 0, 1), HaltByte};
      // 10 c1, 16 c0, 36, 16, 02, 22, 69
      setProg(1, "alu chain", 8'hC0, 8'h00, 8'h20, 8'h69, 7, 5);
      code[2] = '{instr(NOP, 0, 0), instr(LDI, 1, 0), 8'h40, instr(LDI, 2, 0), 8'h41,
                  instr(LD, 0, 1), instr(ST, 0, 2), HaltByte, HaltByte, HaltByte, HaltByte,
                  HaltByte, HaltByte, HaltByte, HaltByte, HaltByte};
      setProg(2, "load and copy", 8'h40, 8'hA7, 8'h41, 8'hA7, 2, 4);
      code[3] = '{instr(SUB, 0, 0), instr(JZ, 0, 0), 8'h05, instr(ADDI, 2, 0), 8'h80,
                  instr(ADDI, 2, 0), 8'h01, instr(JZ, 0, 0), 8'h0B, instr(ADDI, 2, 0), 8'h10,
                  instr(ST, 2, 2), instr(JMP, 0, 0), 8'h0F, instr(ST, 0, 2), HaltByte};
      // JZ costs 11 whether taken or not
      setProg(3, "branches", 8'hC0, 8'h00, 8'h11, 8'h11, 2, 6);
      code[4] = '{instr(LDI, 1, 0), 8'h60, instr(CALL, 0, 0), 8'h08, instr(ADDI, 0, 0), 8'h0F,
                  instr(ST, 0, 1), HaltByte, instr(LDI, 0, 0), 8'h70, instr(ST, 0, 1),
                  instr(RET, 0, 0), HaltByte, HaltByte, HaltByte, HaltByte};
      setProg(4, "call and return", 8'hC0, 8'h00, 8'h60, 8'h7F, 2, 6);
   endtask

   task automatic abortRun(string reason);
      $display("%s", reason);
      $display("Errors found");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic checkAddr(string what, addrT got, addrT exp);
      if (got !== exp)
         abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp));
   endtask

   task automatic checkData(string what, dataT got, dataT exp);
      if (got !== exp)
         abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp));
   endtask

   task automatic checkCycles(string what, int got, int exp);
      if (got != exp)
         abortRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", what, got, exp));
   endtask

   task automatic checkPad(string what, logic got, logic exp);
      if (got !== exp)
         abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp));
   endtask

   task automatic checkCount(string what, int got, int exp);
      if (got != exp)
         abortRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", what, got, exp));
   endtask

   task automatic loadImage(int p);
      for (int a = 0; a < MemBytes; a++) begin
         @(posedge Clock);
         #1;
         LoadEn   = 1'b1;
         LoadAddr = addrT'(a);
         LoadData = imageByte(p, a);
      end
      @(posedge Clock);
      #1;
      LoadEn = 1'b0;
   endtask

   task automatic applyReset();
      nReset = 1'b0;
      repeat (ResetCycles) @(posedge Clock);
      #1;
      nReset = 1'b1;
   endtask

   initial begin
      wait (budgetCycles > 0);
      repeat (budgetCycles) @(posedge Clock);
      abortRun($sformatf("Timeout, a program never halted within %0d cycles", budgetCycles));
   end

   initial begin
      int cycles;
      int enbCycles;
      int writesAtHalt;
      Clock    = 1'b0;
      nReset   = 1'b0;
      LoadEn   = 1'b0;
      LoadAddr = '0;
      LoadData = '0;
      buildTable();
      budgetCycles = MarginCycles;
      for (int p = 0; p < NumProgs; p++)
         budgetCycles += predictCycles(p) + OverheadCycles;

      for (int p = 0; p < NumProgs; p++) begin
         loadImage(p);
         applyReset();
         cycles    = 0;
         enbCycles = 0;
         while (!Halted) begin
            @(posedge Clock);
            #1;
            cycles++;
            if (ENB)
               enbCycles++;
         end
         checkCycles({"cycles to Halted in ", progName[p]}, cycles, predictCycles(p));
         checkCount({"ENB pulses in ", progName[p]}, enbCycles, predictTransfers(p));
         if (WriteCount == 0)
            abortRun({"Program ", progName[p], " made no store before HALT"});
         checkAddr({"LastAddr in ", progName[p]}, LastAddr, storeAddr[p]);
         checkData({"LastData in ", progName[p]}, LastData, storeData[p]);

         // Bus must stay quiet once halted
         writesAtHalt = WriteCount;
         repeat (AfterHaltCycles) begin
            @(posedge Clock);
            #1;
            checkPad({"nME after HALT in ", progName[p]}, nME, 1'b1);
            checkPad({"MemEn after HALT in ", progName[p]}, MemEn, 1'b0);
            checkPad({"ENB after HALT in ", progName[p]}, ENB, 1'b0);
            checkPad({"Halted in ", progName[p]}, Halted, 1'b1);
         end
         checkCount({"WriteCount after HALT in ", progName[p]}, WriteCount, writesAtHalt);
      end

      $display("No errors");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+common
common/opcodes.sv
hw/alu.sv
hw/regFile.sv
hw/control/control.sv
hw/datapath/datapath.sv
hw/cpuTop.sv
dv/memModel.sv
dv/tbCpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   --top-module tbCpu -Mdir obj_dir -f vlog.f

./obj_dir/VtbCpu > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
